//--- Bender.yml
package:
  name: aq32_periph

sources:
  - include_dirs:
      - src
    files:
      - src/aq32_pkg.sv
      - src/kb_msg_receiver.sv
      - src/kb_fifo.sv
      - src/cpu_regs.sv
      - src/aq32_periph_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_aq32_periph.sv

//--- build.f
+incdir+src
src/aq32_pkg.sv
src/kb_msg_receiver.sv
src/kb_fifo.sv
src/cpu_regs.sv
src/aq32_periph_top.sv
test/tb_aq32_periph.sv

//--- src/aq32_consts.svh
`ifndef AQ32_CONSTS_SVH
`define AQ32_CONSTS_SVH

//////////////////////////////////////////////////
// CPU register page
//////////////////////////////////////////////////

// Address bits 31..12 of the register page
`define AQ_REGS_PAGE        20'h00002

// Word offsets, address bits 7..2
`define AQ_REG_VCTRL        6'd2     // 0x02008
`define AQ_REG_VSCRX        6'd3     // 0x0200C
`define AQ_REG_VSCRY        6'd4     // 0x02010
`define AQ_REG_VIRQLINE     6'd6     // 0x02018
`define AQ_REG_KEYBUF       6'd7     // 0x0201C

//////////////////////////////////////////////////
// Core specific SPI messages
//////////////////////////////////////////////////

`define AQ_CMD_KEYS         8'h10    // Load keyboard matrix
`define AQ_CMD_KBBUF        8'h11    // One keycode into the buffer

//////////////////////////////////////////////////
// Widths and sizes
//////////////////////////////////////////////////

`define AQ_KEYCODE_W        16
`define AQ_KEYS_W           64
`define AQ_SPI_DATA_W       64
`define AQ_VSCRX_W          9
`define AQ_VSCRY_W          8
`define AQ_VIRQLINE_W       8

// Keyboard buffer entries
`define AQ_KBBUF_DEPTH      16

`endif

//--- src/aq32_periph_top.sv
`include "aq32_consts.svh"

module aq32_periph_top
    import aq32_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  cpu_bus_t              cpu_bus,
    output logic [31:0]           cpu_rddata,

    input  spi_msg_t              spi_msg,
    output logic                  kb_busy,     // SPI side holds off keycodes
    output logic [`AQ_KEYS_W-1:0] keys,
    output video_ctrl_t           video_ctrl
);

    logic     kb_req;
    keycode_t kb_data;
    logic     kb_ack;
    keycode_t kb_head;
    logic     kb_empty;
    logic     kb_pop;
    logic     kb_clear;

    //////////////////////////////////////////////////
    // SPI message receiver
    //////////////////////////////////////////////////
    kb_msg_receiver msg_receiver (
        .clk     (clk),
        .reset   (reset),
        .spi_msg (spi_msg),
        .keys    (keys),
        .kb_req  (kb_req),
        .kb_data (kb_data),
        .kb_ack  (kb_ack),
        .kb_busy (kb_busy)
    );

    //////////////////////////////////////////////////
    // Keyboard buffer
    //////////////////////////////////////////////////
    kb_fifo #(
        .payload_t (keycode_t),
        .depth     (`AQ_KBBUF_DEPTH)
    ) kbbuf (
        .clk     (clk),
        .reset   (reset),
        .req     (kb_req),
        .wr_data (kb_data),
        .ack     (kb_ack),
        .head    (kb_head),
        .empty   (kb_empty),
        .pop     (kb_pop),
        .clear   (kb_clear)
    );

    //////////////////////////////////////////////////
    // CPU registers
    //////////////////////////////////////////////////
    cpu_regs regs (
        .clk        (clk),
        .reset      (reset),
        .cpu_bus    (cpu_bus),
        .rddata     (cpu_rddata),
        .video_ctrl (video_ctrl),
        .kb_head    (kb_head),
        .kb_empty   (kb_empty),
        .kb_pop     (kb_pop),
        .kb_clear   (kb_clear)
    );

endmodule

//--- src/aq32_pkg.sv
`include "aq32_consts.svh"

package aq32_pkg;

    // Single cycle request on the CPU bus
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wrdata;
        logic        wren;
        logic        strobe;
    } cpu_bus_t;

    // Core specific message from the SPI slave
    typedef struct packed {
        logic                      msg_end;   // Message complete, one cycle
        logic [7:0]                cmd;
        logic [`AQ_SPI_DATA_W-1:0] rxdata;
    } spi_msg_t;

    typedef logic [`AQ_KEYCODE_W-1:0] keycode_t;

    // Bit order matches the vctrl register layout
    typedef struct packed {
        logic       tram_page;
        logic       cols80;
        logic       border_remap;
        logic       text_priority;
        logic       sprites_enable;
        logic [1:0] gfx_mode;
        logic       text_enable;
    } vctrl_t;

    typedef struct packed {
        vctrl_t                    vctrl;
        logic [`AQ_VSCRX_W-1:0]    vscrx;
        logic [`AQ_VSCRY_W-1:0]    vscry;
        logic [`AQ_VIRQLINE_W-1:0] virqline;
    } video_ctrl_t;

endpackage

//--- src/cpu_regs.sv
`include "aq32_consts.svh"

module cpu_regs
    import aq32_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // CPU bus
    input  cpu_bus_t    cpu_bus,
    output logic [31:0] rddata,

    output video_ctrl_t video_ctrl,

    // Keyboard buffer read side
    input  keycode_t    kb_head,
    input  logic        kb_empty,
    output logic        kb_pop,
    output logic        kb_clear
);

    logic       regs_strobe;
    logic [5:0] reg_offset;
    logic       sel_vctrl;
    logic       sel_vscrx;
    logic       sel_vscry;
    logic       sel_virqline;
    logic       sel_keybuf;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    assign regs_strobe = cpu_bus.strobe && (cpu_bus.addr[31:12] == `AQ_REGS_PAGE);
    assign reg_offset  = cpu_bus.addr[7:2];

    assign sel_vctrl    = regs_strobe && (reg_offset == `AQ_REG_VCTRL);
    assign sel_vscrx    = regs_strobe && (reg_offset == `AQ_REG_VSCRX);
    assign sel_vscry    = regs_strobe && (reg_offset == `AQ_REG_VSCRY);
    assign sel_virqline = regs_strobe && (reg_offset == `AQ_REG_VIRQLINE);
    assign sel_keybuf   = regs_strobe && (reg_offset == `AQ_REG_KEYBUF);

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////
    always_comb begin
        rddata = '0;    // Unused offsets and other pages
        if (sel_vctrl)
            rddata = {24'b0, video_ctrl.vctrl};
        if (sel_vscrx)
            rddata = {{(32 - `AQ_VSCRX_W){1'b0}}, video_ctrl.vscrx};
        if (sel_vscry)
            rddata = {{(32 - `AQ_VSCRY_W){1'b0}}, video_ctrl.vscry};
        if (sel_virqline)
            rddata = {{(32 - `AQ_VIRQLINE_W){1'b0}}, video_ctrl.virqline};
        if (sel_keybuf)
            rddata = {kb_empty, 15'b0, kb_head};
    end

    // Read pops the head, write flushes the buffer
    assign kb_pop   = sel_keybuf && !cpu_bus.wren && !kb_empty;
    assign kb_clear = sel_keybuf && cpu_bus.wren;

    //////////////////////////////////////////////////
    // Video control registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            video_ctrl <= '0;
        end else if (cpu_bus.wren) begin
            if (sel_vctrl)
                video_ctrl.vctrl <= vctrl_t'(cpu_bus.wrdata[7:0]);
            if (sel_vscrx)
                video_ctrl.vscrx <= cpu_bus.wrdata[`AQ_VSCRX_W-1:0];
            if (sel_vscry)
                video_ctrl.vscry <= cpu_bus.wrdata[`AQ_VSCRY_W-1:0];
            // Own select for virqline
            if (sel_virqline)
                video_ctrl.virqline <= cpu_bus.wrdata[`AQ_VIRQLINE_W-1:0];
        end
    end

    a_pop_clear_excl: assert property (
        @(posedge clk) disable iff (reset) !(kb_pop && kb_clear)
    );

endmodule

//--- src/kb_fifo.sv
`include "aq32_consts.svh"

module kb_fifo
    import aq32_pkg::*;
#(
    parameter type payload_t = keycode_t,
    parameter int  depth     = `AQ_KBBUF_DEPTH
) (
    input  logic     clk,
    input  logic     reset,

    // Write side, four-phase handshake
    input  logic     req,
    input  payload_t wr_data,
    output logic     ack,

    // Read side
    output payload_t head,
    output logic     empty,
    input  logic     pop,
    input  logic     clear
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;
    logic             do_pop;

    // Wraps at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty  = (count == '0);
    assign full   = (count == cnt_w'(depth));
    assign push   = req && !ack && !full;    // Full holds ack low
    assign do_pop = pop && !empty;
    assign head   = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack    <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                ack <= 1'b1;
            else if (ack && !req)
                ack <= 1'b0;

            if (clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push)   wr_ptr <= next_ptr(wr_ptr);
                if (do_pop) rd_ptr <= next_ptr(rd_ptr);
                case ({push, do_pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // Storage, word lands on the edge that raises ack
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) count <= cnt_w'(depth)
    );

endmodule

//--- src/kb_msg_receiver.sv
`include "aq32_consts.svh"

module kb_msg_receiver
    import aq32_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  spi_msg_t              spi_msg,
    output logic [`AQ_KEYS_W-1:0] keys,

    // Keycode handshake towards the buffer
    output logic                  kb_req,
    output keycode_t              kb_data,
    input  logic                  kb_ack,
    output logic                  kb_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,          // req high, waiting for ack
        S_RELEASE       // req low, waiting for ack to drop
    } hs_state_t;

    hs_state_t state;
    logic      keys_msg;
    logic      kbbuf_msg;
    logic      kbbuf_start;

    assign keys_msg    = spi_msg.msg_end && (spi_msg.cmd == `AQ_CMD_KEYS);
    assign kbbuf_msg   = spi_msg.msg_end && (spi_msg.cmd == `AQ_CMD_KBBUF);
    assign kbbuf_start = kbbuf_msg && (state == S_IDLE);   // Dropped when busy

    //////////////////////////////////////////////////
    // Keyboard matrix
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keys <= '0;
        end else if (keys_msg) begin
            keys <= spi_msg.rxdata[`AQ_KEYS_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // Four-phase handshake
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:    if (kbbuf_start) state <= S_REQ;
                S_REQ:     if (kb_ack) state <= S_RELEASE;
                S_RELEASE: if (!kb_ack) state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // Held from capture until the next message is accepted
    always_ff @(posedge clk) begin
        if (kbbuf_start) begin
            kb_data <= keycode_t'(spi_msg.rxdata[`AQ_KEYCODE_W-1:0]);
        end
    end

    assign kb_req  = (state == S_REQ);
    assign kb_busy = (state != S_IDLE);    // Until ack has fallen

    // Buffer samples the word at any point while req is up
    a_data_stable: assert property (
        @(posedge clk) disable iff (reset)
        kb_req |=> (!kb_req || $stable(kb_data))
    );

endmodule

//--- test/tb_aq32_periph.sv
`include "aq32_consts.svh"

module tb_aq32_periph
    import aq32_pkg::*;
();

    logic                  clk = 1'b0;
    logic                  reset;
    cpu_bus_t              cpu_bus;
    logic [31:0]           cpu_rddata;
    spi_msg_t              spi_msg;
    logic                  kb_busy;
    logic [`AQ_KEYS_W-1:0] keys;
    video_ctrl_t           video_ctrl;

    // Scoreboard
    logic [31:0]           exp_rd;
    logic [31:0]           rd_mask;     // Bits of rddata that are compared
    video_ctrl_t           exp_video;
    logic [`AQ_KEYS_W-1:0] exp_keys;
    keycode_t              exp_q[$];
    logic [31:0]           lfsr = 32'h37305f46;

    aq32_periph_top DUT (.*);

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[62:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [5:0] off);
        return {`AQ_REGS_PAGE, 4'h0, off, 2'b00};
    endfunction

    // Readback is the register zero-extended from its width
    function automatic logic [31:0] video_value(input logic [5:0] off);
        case (off)
            `AQ_REG_VCTRL:    return {24'h0, exp_video.vctrl};
            `AQ_REG_VSCRX:    return {23'h0, exp_video.vscrx};
            `AQ_REG_VSCRY:    return {24'h0, exp_video.vscry};
            `AQ_REG_VIRQLINE: return {24'h0, exp_video.virqline};
            default:          return 32'h0;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // One strobe cycle, then the bus goes idle
    task automatic bus_access(input logic wren, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] exp,
                              input logic [31:0] mask);
        @(posedge clk);
        cpu_bus <= '{addr: addr, wrdata: data, wren: wren, strobe: 1'b1};
        exp_rd  = exp;
        rd_mask = mask;
        @(posedge clk);
        cpu_bus <= '0;
    endtask

    task automatic write_video(input logic [5:0] off, input logic [31:0] data);
        bus_access(1'b1, reg_addr(off), data, '0, '0);
        case (off)
            `AQ_REG_VCTRL:    exp_video.vctrl    = vctrl_t'(data[7:0]);
            `AQ_REG_VSCRX:    exp_video.vscrx    = data[8:0];
            `AQ_REG_VSCRY:    exp_video.vscry    = data[7:0];
            `AQ_REG_VIRQLINE: exp_video.virqline = data[7:0];
            default:          ;
        endcase
    endtask

    task automatic read_keybuf();
        if (exp_q.size() == 0)
            bus_access(1'b0, reg_addr(`AQ_REG_KEYBUF), '0, 32'h8000_0000, 32'h8000_0000);
        else
            bus_access(1'b0, reg_addr(`AQ_REG_KEYBUF), '0, {16'h0, exp_q.pop_front()}, '1);
    endtask

    task automatic wait_not_busy();
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            if (!kb_busy)
                return;
        end
        abort_run("Timeout: kb_busy did not fall after a keycode message");
    endtask

    task automatic send_keys(input logic [63:0] data);
        @(posedge clk);
        spi_msg <= '{msg_end: 1'b1, cmd: `AQ_CMD_KEYS, rxdata: data};
        @(posedge clk);
        spi_msg  <= '0;
        exp_keys = data;    // Visible from the next edge
    endtask

    task automatic send_keycode(input bit wait_done);
        logic [63:0] data;
        data = rand_bits(64);
        exp_q.push_back(data[15:0]);
        @(posedge clk);
        spi_msg <= '{msg_end: 1'b1, cmd: `AQ_CMD_KBBUF, rxdata: data};
        @(posedge clk);
        spi_msg <= '0;
        if (wait_done)
            wait_not_busy();
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    a_read_data: assert property (
        @(posedge clk) disable iff (reset)
        (cpu_bus.strobe && !cpu_bus.wren) |-> (((cpu_rddata ^ exp_rd) & rd_mask) == 32'h0)
    ) else abort_run($sformatf("FAILED %0t: read at %h returned %h, expected %h",
                               $time, $sampled(cpu_bus.addr), $sampled(cpu_rddata),
                               $sampled(exp_rd)));

    a_video: assert property (@(posedge clk) disable iff (reset) video_ctrl == exp_video)
        else abort_run($sformatf("FAILED %0t: video_ctrl is %h, expected %h",
                                 $time, $sampled(video_ctrl), $sampled(exp_video)));

    a_keys: assert property (@(posedge clk) disable iff (reset) keys == exp_keys)
        else abort_run($sformatf("FAILED %0t: keys is %h, expected %h",
                                 $time, $sampled(keys), $sampled(exp_keys)));

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [5:0]  off;
        logic [31:0] addr;
        logic [1:0]  sel;
        reset     = 1'b1;
        cpu_bus   = '0;
        spi_msg   = '0;
        exp_rd    = '0;
        rd_mask   = '0;
        exp_video = '0;
        exp_keys  = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Reset values
        bus_access(1'b0, reg_addr(`AQ_REG_VCTRL), '0, 32'h0, '1);
        bus_access(1'b0, reg_addr(`AQ_REG_VSCRX), '0, 32'h0, '1);
        bus_access(1'b0, reg_addr(`AQ_REG_VSCRY), '0, 32'h0, '1);
        bus_access(1'b0, reg_addr(`AQ_REG_VIRQLINE), '0, 32'h0, '1);
        read_keybuf();

        // Other pages and unused offsets
        for (int i = 0; i < 16; i++) begin
            addr = 32'(rand_bits(32));
            if (addr[31:12] == `AQ_REGS_PAGE)
                addr[31] = ~addr[31];
            bus_access(1'b0, addr, '0, 32'h0, '1);
            bus_access(1'b1, addr, 32'(rand_bits(32)), '0, '0);
            off = 6'(rand_bits(6));
            if (off inside {`AQ_REG_VCTRL, `AQ_REG_VSCRX, `AQ_REG_VSCRY,
                            `AQ_REG_VIRQLINE, `AQ_REG_KEYBUF})
                off = 6'd5;
            bus_access(1'b0, reg_addr(off), '0, 32'h0, '1);
            bus_access(1'b1, reg_addr(off), 32'(rand_bits(32)), '0, '0);
        end

        for (int i = 0; i < 24; i++) begin
            sel = 2'(rand_bits(2));
            case (sel)
                2'd0:    off = `AQ_REG_VCTRL;
                2'd1:    off = `AQ_REG_VSCRX;
                2'd2:    off = `AQ_REG_VSCRY;
                default: off = `AQ_REG_VIRQLINE;
            endcase
            write_video(off, 32'(rand_bits(32)));
            bus_access(1'b0, reg_addr(off), '0, video_value(off), '1);
        end

        repeat (4) send_keys(rand_bits(64));

        // Keycodes in order, then empty
        repeat (6) send_keycode(1'b1);
        repeat (7) read_keybuf();

        // Full buffer keeps the last keycode waiting
        repeat (`AQ_KBBUF_DEPTH) send_keycode(1'b1);
        send_keycode(1'b0);
        repeat (20) begin
            @(negedge clk);
            assert (kb_busy)
                else abort_run($sformatf("FAILED %0t: kb_busy fell while the buffer was full",
                                         $time));
        end
        read_keybuf();
        wait_not_busy();
        repeat (`AQ_KBBUF_DEPTH + 1) read_keybuf();

        // Write to keybuf flushes the buffer
        repeat (5) send_keycode(1'b1);
        bus_access(1'b1, reg_addr(`AQ_REG_KEYBUF), 32'(rand_bits(32)), '0, '0);
        exp_q.delete();
        read_keybuf();

        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule
